/* common/axi_defines.svh */
`ifndef AXI_DEFINES_SVH
`define AXI_DEFINES_SVH

// bus field widths
`define AXI_ADDR_W      32
`define AXI_DATA_W      32
`define AXI_STRB_W      4
`define AXI_LEN_W       8
`define AXI_ID_W        4

// on-chip memory depth in words
`define MEM_WORDS_LOG2  10

// read master ids
`define ID_DCACHE       0
`define ID_ICACHE       1

`endif

/* common/axi_pkg.sv */
`include "axi_defines.svh"

package axi_pkg;

    // cache read request, before an id is attached
    typedef struct packed {
        logic [`AXI_ADDR_W-1:0] addr;
        logic [`AXI_LEN_W-1:0]  len;
    } cache_rd_req_t;

    // read address channel
    typedef struct packed {
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_ADDR_W-1:0] addr;
        logic [`AXI_LEN_W-1:0]  len;
    } axi_ar_t;

    // read data channel
    typedef struct packed {
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_DATA_W-1:0] data;
        logic                   last;
    } axi_r_t;

    // write address channel, single writer so no id
    typedef struct packed {
        logic [`AXI_ADDR_W-1:0] addr;
        logic [`AXI_LEN_W-1:0]  len;
    } axi_aw_t;

    // write data channel
    typedef struct packed {
        logic [`AXI_DATA_W-1:0] data;
        logic [`AXI_STRB_W-1:0] strb;
        logic                   last;
    } axi_w_t;

endpackage

/* logic/burst_addr_counter.sv */
`timescale 1ns/100ps
`include "axi_defines.svh"

module burst_addr_counter (
    input  logic                        clk,
    input  logic                        i_rst_n,
    input  logic                        i_load,
    input  logic [`MEM_WORDS_LOG2-1:0]  i_start_word,
    input  logic [`AXI_LEN_W-1:0]       i_len,
    input  logic                        i_step,
    output logic [`MEM_WORDS_LOG2-1:0]  o_word,
    output logic                        o_last
);

    logic [`AXI_LEN_W-1:0] len_q;
    logic [`AXI_LEN_W-1:0] beat_q;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_word <= '0;
            len_q  <= '0;
            beat_q <= '0;
        end else if (i_load) begin
            o_word <= i_start_word;
            len_q  <= i_len;
            beat_q <= '0;
        end else if (i_step) begin
            // word address wraps at the top of memory
            o_word <= o_word + 1'b1;
            beat_q <= beat_q + 1'b1;
        end
    end

    assign o_last = (beat_q == len_q);

endmodule

/* arbiter/cache_axi_arbiter.sv */
`timescale 1ns/100ps
`include "axi_defines.svh"

module cache_axi_arbiter (
    input  logic                     clk,
    input  logic                     i_rst_n,
    // instruction cache read
    input  axi_pkg::cache_rd_req_t   i_icache_req,
    input  logic                     i_icache_req_valid,
    output logic                     o_icache_req_ready,
    output logic [`AXI_DATA_W-1:0]   o_icache_rdata,
    output logic                     o_icache_rlast,
    output logic                     o_icache_rvalid,
    input  logic                     i_icache_rready,
    // data cache read
    input  axi_pkg::cache_rd_req_t   i_dcache_req,
    input  logic                     i_dcache_req_valid,
    output logic                     o_dcache_req_ready,
    output logic [`AXI_DATA_W-1:0]   o_dcache_rdata,
    output logic                     o_dcache_rlast,
    output logic                     o_dcache_rvalid,
    input  logic                     i_dcache_rready,
    // data cache write
    input  axi_pkg::axi_aw_t         i_dcache_aw,
    input  logic                     i_dcache_aw_valid,
    output logic                     o_dcache_aw_ready,
    input  axi_pkg::axi_w_t          i_dcache_w,
    input  logic                     i_dcache_w_valid,
    output logic                     o_dcache_w_ready,
    output logic                     o_dcache_bvalid,
    input  logic                     i_dcache_bready,
    // memory bus
    output axi_pkg::axi_ar_t         o_ar,
    output logic                     o_arvalid,
    input  logic                     i_arready,
    input  axi_pkg::axi_r_t          i_r,
    input  logic                     i_rvalid,
    output logic                     o_rready,
    output axi_pkg::axi_aw_t         o_aw,
    output logic                     o_awvalid,
    input  logic                     i_awready,
    output axi_pkg::axi_w_t          o_w,
    output logic                     o_wvalid,
    input  logic                     i_wready,
    input  logic                     i_bvalid,
    output logic                     o_bready
);

    localparam logic [`AXI_ID_W-1:0] ID_D = `ID_DCACHE;
    localparam logic [`AXI_ID_W-1:0] ID_I = `ID_ICACHE;

    logic grant_held;
    logic grant_icache_q;
    logic sel_icache;
    logic beat_to_icache;
    logic beat_to_dcache;

    // dcache has priority unless the icache already owns a pending address
    assign sel_icache = grant_held ? grant_icache_q : ~i_dcache_req_valid;

    // keep the winner while its address waits for arready
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            grant_held     <= 1'b0;
            grant_icache_q <= 1'b0;
        end else begin
            grant_held     <= o_arvalid & ~i_arready;
            grant_icache_q <= sel_icache;
        end
    end

    // address mux, winner's id stamped in
    always_comb begin
        if (sel_icache) begin
            o_ar.id   = ID_I;
            o_ar.addr = i_icache_req.addr;
            o_ar.len  = i_icache_req.len;
            o_arvalid = i_icache_req_valid;
        end else begin
            o_ar.id   = ID_D;
            o_ar.addr = i_dcache_req.addr;
            o_ar.len  = i_dcache_req.len;
            o_arvalid = i_dcache_req_valid;
        end
    end

    assign o_icache_req_ready = i_arready & sel_icache;
    // dcache is only locked out while the icache holds the grant
    assign o_dcache_req_ready = i_arready & ~(grant_held & grant_icache_q);

    // route each beat by id
    assign beat_to_icache = (i_r.id == ID_I);
    assign beat_to_dcache = (i_r.id == ID_D);

    assign o_icache_rdata  = i_r.data;
    assign o_icache_rlast  = i_r.last;
    assign o_icache_rvalid = i_rvalid & beat_to_icache;

    assign o_dcache_rdata  = i_r.data;
    assign o_dcache_rlast  = i_r.last;
    assign o_dcache_rvalid = i_rvalid & beat_to_dcache;

    always_comb begin
        if (beat_to_icache) begin
            o_rready = i_icache_rready;
        end else if (beat_to_dcache) begin
            o_rready = i_dcache_rready;
        end else begin
            o_rready = 1'b0;
        end
    end

    // write side belongs to the dcache alone
    assign o_aw              = i_dcache_aw;
    assign o_awvalid         = i_dcache_aw_valid;
    assign o_dcache_aw_ready = i_awready;
    assign o_w               = i_dcache_w;
    assign o_wvalid          = i_dcache_w_valid;
    assign o_dcache_w_ready  = i_wready;
    assign o_dcache_bvalid   = i_bvalid;
    assign o_bready          = i_dcache_bready;

endmodule

/* logic/axi_burst_ram.sv */
`timescale 1ns/100ps
`include "axi_defines.svh"

module axi_burst_ram (
    input  logic              clk,
    input  logic              i_rst_n,
    // read
    input  axi_pkg::axi_ar_t  i_ar,
    input  logic              i_arvalid,
    output logic              o_arready,
    output axi_pkg::axi_r_t   o_r,
    output logic              o_rvalid,
    input  logic              i_rready,
    // write
    input  axi_pkg::axi_aw_t  i_aw,
    input  logic              i_awvalid,
    output logic              o_awready,
    input  axi_pkg::axi_w_t   i_w,
    input  logic              i_wvalid,
    output logic              o_wready,
    output logic              o_bvalid,
    input  logic              i_bready
);

    localparam int WORDS = 1 << `MEM_WORDS_LOG2;

    logic [`AXI_DATA_W-1:0] mem [0:WORDS-1];

    // read side
    logic                       rd_active;
    logic [`AXI_ID_W-1:0]       rd_id;
    logic                       ar_fire;
    logic                       r_fire;
    logic [`MEM_WORDS_LOG2-1:0] rd_word;
    logic                       rd_last;

    // write side, active from aw accept until the response is taken
    logic                       wr_active;
    logic                       aw_fire;
    logic                       w_fire;
    logic [`MEM_WORDS_LOG2-1:0] wr_word;

    assign ar_fire = i_arvalid & o_arready;
    assign r_fire  = o_rvalid & i_rready;
    assign aw_fire = i_awvalid & o_awready;
    assign w_fire  = i_wvalid & o_wready;

    assign o_arready = ~rd_active;
    assign o_rvalid  = rd_active;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rd_active <= 1'b0;
            rd_id     <= '0;
        end else if (ar_fire) begin
            rd_active <= 1'b1;
            rd_id     <= i_ar.id;
        end else if (r_fire && rd_last) begin
            rd_active <= 1'b0;
        end
    end

    // byte address to word index, low two bits dropped
    burst_addr_counter u_rd_cnt (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_load       (ar_fire),
        .i_start_word (i_ar.addr[`MEM_WORDS_LOG2+1:2]),
        .i_len        (i_ar.len),
        .i_step       (r_fire),
        .o_word       (rd_word),
        .o_last       (rd_last)
    );

    // data held stable while the cache stalls
    always_comb begin
        o_r.id   = rd_id;
        o_r.data = mem[rd_word];
        o_r.last = rd_last;
    end

    assign o_awready = ~wr_active;
    assign o_wready  = wr_active & ~o_bvalid;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_active <= 1'b0;
            o_bvalid  <= 1'b0;
        end else begin
            if (aw_fire) begin
                wr_active <= 1'b1;
            end else if (o_bvalid && i_bready) begin
                wr_active <= 1'b0;
            end

            if (w_fire && i_w.last) begin
                o_bvalid <= 1'b1;
            end else if (i_bready) begin
                o_bvalid <= 1'b0;
            end
        end
    end

    // burst end comes from wlast
    burst_addr_counter u_wr_cnt (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_load       (aw_fire),
        .i_start_word (i_aw.addr[`MEM_WORDS_LOG2+1:2]),
        .i_len        (i_aw.len),
        .i_step       (w_fire),
        .o_word       (wr_word),
        .o_last       ()
    );

    // merge enabled bytes into the current word
    always_ff @(posedge clk) begin
        if (w_fire) begin
            for (int b = 0; b < `AXI_STRB_W; b++) begin
                if (i_w.strb[b]) begin
                    mem[wr_word][8*b +: 8] <= i_w.data[8*b +: 8];
                end
            end
        end
    end

endmodule

/* logic/cache_mem_top.sv */
`timescale 1ns/100ps
`include "axi_defines.svh"

module cache_mem_top (
    input  logic                     clk,
    input  logic                     i_rst_n,
    // instruction cache
    input  axi_pkg::cache_rd_req_t   i_icache_req,
    input  logic                     i_icache_req_valid,
    output logic                     o_icache_req_ready,
    output logic [`AXI_DATA_W-1:0]   o_icache_rdata,
    output logic                     o_icache_rlast,
    output logic                     o_icache_rvalid,
    input  logic                     i_icache_rready,
    // data cache
    input  axi_pkg::cache_rd_req_t   i_dcache_req,
    input  logic                     i_dcache_req_valid,
    output logic                     o_dcache_req_ready,
    output logic [`AXI_DATA_W-1:0]   o_dcache_rdata,
    output logic                     o_dcache_rlast,
    output logic                     o_dcache_rvalid,
    input  logic                     i_dcache_rready,
    input  axi_pkg::axi_aw_t         i_dcache_aw,
    input  logic                     i_dcache_aw_valid,
    output logic                     o_dcache_aw_ready,
    input  axi_pkg::axi_w_t          i_dcache_w,
    input  logic                     i_dcache_w_valid,
    output logic                     o_dcache_w_ready,
    output logic                     o_dcache_bvalid,
    input  logic                     i_dcache_bready
);

    // arbiter to ram bus
    axi_pkg::axi_ar_t ar;
    axi_pkg::axi_r_t  r;
    axi_pkg::axi_aw_t aw;
    axi_pkg::axi_w_t  w;
    logic             arvalid;
    logic             arready;
    logic             rvalid;
    logic             rready;
    logic             awvalid;
    logic             awready;
    logic             wvalid;
    logic             wready;
    logic             bvalid;
    logic             bready;

    cache_axi_arbiter u_arbiter (
        .clk                (clk),
        .i_rst_n            (i_rst_n),
        .i_icache_req       (i_icache_req),
        .i_icache_req_valid (i_icache_req_valid),
        .o_icache_req_ready (o_icache_req_ready),
        .o_icache_rdata     (o_icache_rdata),
        .o_icache_rlast     (o_icache_rlast),
        .o_icache_rvalid    (o_icache_rvalid),
        .i_icache_rready    (i_icache_rready),
        .i_dcache_req       (i_dcache_req),
        .i_dcache_req_valid (i_dcache_req_valid),
        .o_dcache_req_ready (o_dcache_req_ready),
        .o_dcache_rdata     (o_dcache_rdata),
        .o_dcache_rlast     (o_dcache_rlast),
        .o_dcache_rvalid    (o_dcache_rvalid),
        .i_dcache_rready    (i_dcache_rready),
        .i_dcache_aw        (i_dcache_aw),
        .i_dcache_aw_valid  (i_dcache_aw_valid),
        .o_dcache_aw_ready  (o_dcache_aw_ready),
        .i_dcache_w         (i_dcache_w),
        .i_dcache_w_valid   (i_dcache_w_valid),
        .o_dcache_w_ready   (o_dcache_w_ready),
        .o_dcache_bvalid    (o_dcache_bvalid),
        .i_dcache_bready    (i_dcache_bready),
        .o_ar               (ar),
        .o_arvalid          (arvalid),
        .i_arready          (arready),
        .i_r                (r),
        .i_rvalid           (rvalid),
        .o_rready           (rready),
        .o_aw               (aw),
        .o_awvalid          (awvalid),
        .i_awready          (awready),
        .o_w                (w),
        .o_wvalid           (wvalid),
        .i_wready           (wready),
        .i_bvalid           (bvalid),
        .o_bready           (bready)
    );

    axi_burst_ram u_ram (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_ar      (ar),
        .i_arvalid (arvalid),
        .o_arready (arready),
        .o_r       (r),
        .o_rvalid  (rvalid),
        .i_rready  (rready),
        .i_aw      (aw),
        .i_awvalid (awvalid),
        .o_awready (awready),
        .i_w       (w),
        .i_wvalid  (wvalid),
        .o_wready  (wready),
        .o_bvalid  (bvalid),
        .i_bready  (bready)
    );

endmodule

/* testbench/tb_cache_mem_top.sv */
`timescale 1ns/100ps
`include "axi_defines.svh"

module tb_cache_mem_top;

    localparam int REGION = 64;
    localparam int N_WR   = 6;
    localparam int N_RD   = 6;
    localparam int N_PAIR = 4;
    localparam int N_BP   = 9;
    // init burst plus every later burst at its longest with read-back
    localparam int MAX_BEATS = REGION + 16 * (2 * N_WR + N_RD + 2 * N_PAIR + 2 * N_BP);

    logic                   clk;
    logic                   i_rst_n;
    axi_pkg::cache_rd_req_t i_icache_req;
    logic                   i_icache_req_valid;
    logic                   o_icache_req_ready;
    logic [`AXI_DATA_W-1:0] o_icache_rdata;
    logic                   o_icache_rlast;
    logic                   o_icache_rvalid;
    logic                   i_icache_rready = 1'b1;
    axi_pkg::cache_rd_req_t i_dcache_req;
    logic                   i_dcache_req_valid;
    logic                   o_dcache_req_ready;
    logic [`AXI_DATA_W-1:0] o_dcache_rdata;
    logic                   o_dcache_rlast;
    logic                   o_dcache_rvalid;
    logic                   i_dcache_rready = 1'b1;
    axi_pkg::axi_aw_t       i_dcache_aw;
    logic                   i_dcache_aw_valid;
    logic                   o_dcache_aw_ready;
    axi_pkg::axi_w_t        i_dcache_w;
    logic                   i_dcache_w_valid;
    logic                   o_dcache_w_ready;
    logic                   o_dcache_bvalid;
    logic                   i_dcache_bready;

    // mirror of the low memory region
    logic [`AXI_DATA_W-1:0] model [0:REGION-1];
    // outstanding bursts per cache packed as start * 256 + len
    int     d_q[$];
    int     i_q[$];
    int     beat_idx [0:1];
    int     done_order[$];
    int     b_count;
    int     wr_bursts;
    int     err_count;
    int     check_count;
    integer seed = 93623;
    integer gap_seed;
    bit     bp_en;
    string  test_name;

    cache_mem_top u_dut (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    function automatic logic [`AXI_DATA_W-1:0] merge_bytes(
        input logic [`AXI_DATA_W-1:0] old_w,
        input logic [`AXI_DATA_W-1:0] new_w,
        input logic [`AXI_STRB_W-1:0] strb
    );
        logic [`AXI_DATA_W-1:0] res;
        res = old_w;
        for (int b = 0; b < `AXI_STRB_W; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic logic [`AXI_DATA_W-1:0] expected_word(input int start, input int idx);
        return model[start + idx];
    endfunction

    // odd multiplier spreads the whole word index over every byte
    function automatic logic [`AXI_DATA_W-1:0] fill_word(input int w);
        logic [31:0] v;
        v = w;
        return (v * 32'h9e37_79b1) ^ 32'hc35a_a53c;
    endfunction

    task automatic check_eq(input string what, input logic [`AXI_DATA_W-1:0] exp_v,
                            input logic [`AXI_DATA_W-1:0] act_v);
        check_count++;
        assert (act_v === exp_v) else begin
            err_count++;
            $display("[FAIL] %s: %s expected %h actual %h", test_name, what, exp_v, act_v);
        end
    endtask

    task automatic check_beat(input int c, input logic taken,
                              input logic [`AXI_DATA_W-1:0] data, input logic last);
        bit has_req;
        int entry;
        int len;
        has_req = (c == 0) ? (d_q.size() != 0) : (i_q.size() != 0);
        check_count++;
        assert (has_req) else begin
            err_count++;
            $display("%s: %s saw rvalid without an outstanding read", test_name,
                     (c == 0) ? "dcache" : "icache");
        end
        if (!has_req) begin
            return;
        end
        entry = (c == 0) ? d_q[0] : i_q[0];
        len = entry % 256;
        // a stalled beat must keep its data and last
        check_eq("rdata", expected_word(entry / 256, beat_idx[c]), data);
        check_eq("rlast", beat_idx[c] == len, last);
        if (!taken) begin
            return;
        end
        if (beat_idx[c] == len) begin
            beat_idx[c] = 0;
            done_order.push_back(c);
            if (c == 0) begin
                void'(d_q.pop_front());
            end else begin
                void'(i_q.pop_front());
            end
        end else begin
            beat_idx[c]++;
        end
    endtask

    // compare process
    always @(posedge clk) begin
        if (i_rst_n) begin
            if (o_dcache_rvalid) begin
                check_beat(0, i_dcache_rready, o_dcache_rdata, o_dcache_rlast);
            end
            if (o_icache_rvalid) begin
                check_beat(1, i_icache_rready, o_icache_rdata, o_icache_rlast);
            end
            if (o_dcache_bvalid && i_dcache_bready) begin
                b_count++;
            end
        end
    end

    // receiver stalls about one cycle in four
    always @(negedge clk) begin
        if (bp_en) begin
            i_dcache_rready = ($random(gap_seed) & 3) != 0;
            i_icache_rready = ($random(gap_seed) & 3) != 0;
        end else begin
            i_dcache_rready = 1'b1;
            i_icache_rready = 1'b1;
        end
    end

    task automatic pick_burst(output int start, output int len);
        start = $random(seed) & 47;
        len = $random(seed) & 15;
    endtask

    task automatic write_burst(input int start, input int len, input bit fill);
        logic [`AXI_DATA_W-1:0] data;
        logic [31:0]            rnd;
        @(negedge clk);
        i_dcache_aw.addr = start * 4;
        i_dcache_aw.len = len[7:0];
        i_dcache_aw_valid = 1'b1;
        @(posedge clk);
        while (!o_dcache_aw_ready) @(posedge clk);
        for (int i = 0; i <= len; i++) begin
            @(negedge clk);
            i_dcache_aw_valid = 1'b0;
            rnd = $random(seed);
            data = fill ? fill_word(start + i) : $random(seed);
            i_dcache_w.data = data;
            i_dcache_w.strb = fill ? 4'hf : rnd[3:0];
            i_dcache_w.last = (i == len);
            i_dcache_w_valid = 1'b1;
            @(posedge clk);
            while (!o_dcache_w_ready) @(posedge clk);
            model[start + i] = merge_bytes(model[start + i], data, i_dcache_w.strb);
        end
        @(negedge clk);
        i_dcache_w_valid = 1'b0;
        wr_bursts++;
        while (b_count < wr_bursts) @(posedge clk);
    endtask

    task automatic issue_reads(input bit use_d, input int d_start, input int d_len,
                               input bit use_i, input int i_start, input int i_len);
        bit          d_acc;
        bit          i_acc;
        logic [31:0] rnd;
        @(negedge clk);
        rnd = $random(seed);
        // junk low address bits that the RAM drops
        if (use_d) begin
            d_q.push_back(d_start * 256 + d_len);
            i_dcache_req.addr = d_start * 4 + rnd[1:0];
            i_dcache_req.len = d_len[7:0];
            i_dcache_req_valid = 1'b1;
        end
        if (use_i) begin
            i_q.push_back(i_start * 256 + i_len);
            i_icache_req.addr = i_start * 4 + rnd[3:2];
            i_icache_req.len = i_len[7:0];
            i_icache_req_valid = 1'b1;
        end
        while (i_dcache_req_valid || i_icache_req_valid) begin
            @(posedge clk);
            d_acc = i_dcache_req_valid && o_dcache_req_ready;
            i_acc = i_icache_req_valid && o_icache_req_ready;
            @(negedge clk);
            if (d_acc) begin
                i_dcache_req_valid = 1'b0;
            end
            if (i_acc) begin
                i_icache_req_valid = 1'b0;
            end
        end
    endtask

    task automatic wait_reads_done();
        while (d_q.size() != 0 || i_q.size() != 0) @(posedge clk);
        @(negedge clk);
    endtask

    initial begin
        int s1;
        int l1;
        int s2;
        int l2;
        gap_seed = seed + 1;
        i_rst_n = 1'b0;
        i_icache_req = '0;
        i_icache_req_valid = 1'b0;
        i_dcache_req = '0;
        i_dcache_req_valid = 1'b0;
        i_dcache_aw = '0;
        i_dcache_aw_valid = 1'b0;
        i_dcache_w = '0;
        i_dcache_w_valid = 1'b0;
        i_dcache_bready = 1'b1;
        beat_idx[0] = 0;
        beat_idx[1] = 0;
        b_count = 0;
        wr_bursts = 0;
        err_count = 0;
        check_count = 0;
        bp_en = 1'b0;
        test_name = "reset";
        repeat (3) @(posedge clk);
        @(negedge clk);
        i_rst_n = 1'b1;
        @(posedge clk);
        check_eq("icache rvalid", 0, o_icache_rvalid);
        check_eq("dcache rvalid", 0, o_dcache_rvalid);
        check_eq("bvalid", 0, o_dcache_bvalid);
        check_eq("icache req ready", 1, o_icache_req_ready);
        check_eq("dcache req ready", 1, o_dcache_req_ready);

        test_name = "write";
        write_burst(0, REGION - 1, 1'b1);
        for (int n = 0; n < N_WR; n++) begin
            pick_burst(s1, l1);
            write_burst(s1, l1, 1'b0);
            issue_reads(1'b1, s1, l1, 1'b0, 0, 0);
            wait_reads_done();
        end
        repeat (5) @(posedge clk);
        check_eq("write responses", N_WR + 1, b_count);

        test_name = "single";
        for (int n = 0; n < N_RD; n++) begin
            pick_burst(s1, l1);
            issue_reads(n % 2 == 0, s1, l1, n % 2 == 1, s1, l1);
            wait_reads_done();
        end

        // dcache reads the lower half and icache the upper half
        test_name = "pair";
        for (int n = 0; n < N_PAIR; n++) begin
            pick_burst(s1, l1);
            pick_burst(s2, l2);
            done_order.delete();
            issue_reads(1'b1, s1 & 15, l1, 1'b1, (s2 & 15) + 32, l2);
            wait_reads_done();
            // cache index 0 is the dcache
            check_eq("first burst done", 0, done_order[0]);
            check_eq("second burst done", 1, done_order[1]);
        end

        test_name = "backpressure";
        bp_en = 1'b1;
        for (int n = 0; n < N_BP; n++) begin
            pick_burst(s1, l1);
            pick_burst(s2, l2);
            issue_reads(n % 3 != 1, s1 & 15, l1, n % 3 != 0, (s2 & 15) + 32, l2);
            wait_reads_done();
        end
        bp_en = 1'b0;
        repeat (5) @(posedge clk);

        $display("checks %0d, errors %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (MAX_BEATS * 20 + 1000) @(posedge clk);
        $display("timeout in test %s, the bus stopped making progress", test_name);
        $display("checks %0d, errors %0d", check_count, err_count);
        $display("TB FAILED");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+common
common/axi_pkg.sv
logic/burst_addr_counter.sv
arbiter/cache_axi_arbiter.sv
logic/axi_burst_ram.sv
logic/cache_mem_top.sv
testbench/tb_cache_mem_top.sv

/* Makefile */
# Verilator flow for the cache memory port

VERILATOR ?= verilator
FILELIST  ?= filelist.f
TOP       ?= tb_cache_mem_top
RTL_TOP   ?= cache_mem_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "TB PASSED" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
